//--- source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [15:0] word_t;
    typedef logic [3:0] operand_t;

    typedef enum logic [3:0] {
        op_copy = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_and  = 4'd3,
        op_or   = 4'd4,
        op_xor  = 4'd5,
        op_shl  = 4'd6,
        op_shr  = 4'd7
    } alu_op_t;

    typedef enum logic [2:0] {
        eff_always    = 3'd0,
        eff_zero      = 3'd1,
        eff_not_zero  = 3'd2,
        eff_carry     = 3'd3,
        eff_not_carry = 3'd4,
        eff_negative  = 3'd5,
        eff_overflow  = 3'd6,
        eff_never     = 3'd7
    } effect_t;

    // one bit per step
    typedef enum logic [5:0] {
        step_fetch_low  = 6'b000001,
        step_fetch_high = 6'b000010,
        step_operand    = 6'b000100,
        step_source     = 6'b001000,
        step_execute    = 6'b010000,
        step_writeback  = 6'b100000
    } step_t;

    // special operand codes, memory codes sit above flags
    localparam operand_t operand_pc = 4'd0;
    localparam operand_t operand_imm = 4'd7;
    localparam operand_t operand_flags = 4'd8;
    localparam operand_t operand_mem_abs = 4'd15;

    localparam int flag_zero = 0;
    localparam int flag_negative = 1;
    localparam int flag_carry = 2;
    localparam int flag_overflow = 3;

    localparam word_t reset_pc = 16'h0000;
    localparam word_t reset_flags = 16'h0000;
    localparam word_t pc_step = 16'd2;

endpackage

`default_nettype wire

//--- source/step_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module step_sequencer (
    input wire cpu_clock,
    input wire reset,
    input wire copy_op,
    output cpu_pkg::step_t step
);

    cpu_pkg::step_t step_next;

    always_comb begin
        case (step)
            cpu_pkg::step_fetch_low: step_next = cpu_pkg::step_fetch_high;
            cpu_pkg::step_fetch_high: step_next = cpu_pkg::step_operand;
            cpu_pkg::step_operand: step_next = cpu_pkg::step_source;
            // copies have nothing to compute
            cpu_pkg::step_source: begin
                step_next = copy_op ? cpu_pkg::step_writeback : cpu_pkg::step_execute;
            end
            cpu_pkg::step_execute: step_next = cpu_pkg::step_writeback;
            cpu_pkg::step_writeback: step_next = cpu_pkg::step_fetch_low;
            default: step_next = cpu_pkg::step_fetch_low;
        endcase
    end

    always_ff @(posedge cpu_clock) begin
        if (reset) begin
            step <= cpu_pkg::step_fetch_low;
        end else begin
            step <= step_next;
        end
    end

endmodule

`default_nettype wire

//--- source/instruction_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module instruction_decoder (
    input wire cpu_clock,
    input wire reset,
    input wire cpu_pkg::step_t step,
    input wire cpu_pkg::word_t mem_read_data,
    input wire cpu_pkg::word_t flags,
    output cpu_pkg::operand_t src,
    output cpu_pkg::operand_t dst,
    output cpu_pkg::alu_op_t op,
    output cpu_pkg::word_t imm,
    output logic src_mem,
    output logic dst_mem,
    output logic copy_op,
    output logic store_en
);

    cpu_pkg::word_t imm_q;

    function automatic logic effect_taken(
        input cpu_pkg::effect_t effect,
        input cpu_pkg::word_t f
    );
        logic taken;
        case (effect)
            cpu_pkg::eff_always: taken = 1'b1;
            cpu_pkg::eff_zero: taken = f[cpu_pkg::flag_zero];
            cpu_pkg::eff_not_zero: taken = ~f[cpu_pkg::flag_zero];
            cpu_pkg::eff_carry: taken = f[cpu_pkg::flag_carry];
            cpu_pkg::eff_not_carry: taken = ~f[cpu_pkg::flag_carry];
            cpu_pkg::eff_negative: taken = f[cpu_pkg::flag_negative];
            cpu_pkg::eff_overflow: taken = f[cpu_pkg::flag_overflow];
            cpu_pkg::eff_never: taken = 1'b0;
            default: taken = 1'b0;
        endcase
        return taken;
    endfunction

    // ==============================
    // first word, arrives in fetch_high
    // ==============================

    always_ff @(posedge cpu_clock) begin
        if (reset) begin
            src <= cpu_pkg::operand_pc;
            dst <= cpu_pkg::operand_pc;
            op <= cpu_pkg::op_copy;
            store_en <= 1'b0;
        end else if (step == cpu_pkg::step_fetch_high) begin
            src <= mem_read_data[15:12];
            dst <= mem_read_data[11:8];
            op <= cpu_pkg::alu_op_t'(mem_read_data[3:0]);
            // flags only move in writeback, so they are settled here
            store_en <= effect_taken(cpu_pkg::effect_t'(mem_read_data[6:4]), flags);
        end
    end

    // ==============================
    // immediate, arrives in operand
    // ==============================

    always_ff @(posedge cpu_clock) begin
        if (step == cpu_pkg::step_operand) begin
            imm_q <= mem_read_data;
        end
    end

    // forwarded so the source address is ready in the same step
    assign imm = (step == cpu_pkg::step_operand) ? mem_read_data : imm_q;

    assign src_mem = src > cpu_pkg::operand_flags;
    assign dst_mem = dst > cpu_pkg::operand_flags;

    // upper op codes behave as copy
    assign copy_op = (op == cpu_pkg::op_copy) | op[3];

endmodule

`default_nettype wire

//--- source/register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file (
    input wire cpu_clock,
    input wire reset,
    input wire cpu_pkg::step_t step,
    input wire cpu_pkg::operand_t src,
    input wire cpu_pkg::operand_t dst,
    input wire cpu_pkg::word_t imm,
    input wire store_en,
    input wire cpu_pkg::word_t result,
    input wire cpu_pkg::word_t alu_flags,
    input wire copy_op,
    output cpu_pkg::word_t pc,
    output cpu_pkg::word_t flags,
    output cpu_pkg::word_t src_base,
    output cpu_pkg::word_t dst_base
);

    cpu_pkg::word_t gpr [1:6];

    // plain value of a code, memory codes give their base register
    function automatic cpu_pkg::word_t operand_value(input cpu_pkg::operand_t code);
        cpu_pkg::word_t value;
        case (code)
            cpu_pkg::operand_pc: value = pc;
            cpu_pkg::operand_imm: value = imm;
            cpu_pkg::operand_flags: value = flags;
            cpu_pkg::operand_mem_abs: value = imm;
            default: value = gpr[code[2:0]];
        endcase
        return value;
    endfunction

    // ==============================
    // operand bases
    // ==============================

    always_comb begin
        src_base = operand_value(src);
        // register plus offset for indexed sources
        if (src > cpu_pkg::operand_flags && src != cpu_pkg::operand_mem_abs) begin
            src_base = src_base + imm;
        end
    end

    always_comb begin
        dst_base = operand_value(dst);
    end

    // ==============================
    // state update
    // ==============================

    always_ff @(posedge cpu_clock) begin
        if (reset) begin
            pc <= cpu_pkg::reset_pc;
            flags <= cpu_pkg::reset_flags;
            for (int i = 1; i <= 6; i++) begin
                gpr[i] <= '0;
            end
        end else begin
            if (step == cpu_pkg::step_fetch_low || step == cpu_pkg::step_fetch_high) begin
                pc <= pc + cpu_pkg::pc_step;
            end
            if (step == cpu_pkg::step_writeback) begin
                if (store_en) begin
                    case (dst)
                        cpu_pkg::operand_pc: pc <= result;
                        cpu_pkg::operand_flags: flags <= result;
                        default: begin
                            if (dst inside {[4'd1:4'd6]}) begin
                                gpr[dst[2:0]] <= result;
                            end
                        end
                    endcase
                end
                // alu flags override a flags destination
                if (!copy_op) begin
                    flags <= alu_flags;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/execute_unit.sv
`timescale 1ns/1ns
`default_nettype none

module execute_unit (
    input wire cpu_clock,
    input wire reset,
    input wire cpu_pkg::step_t step,
    input wire cpu_pkg::alu_op_t op,
    input wire copy_op,
    input wire cpu_pkg::word_t src_val,
    input wire cpu_pkg::word_t dst_val,
    input wire cpu_pkg::word_t flags,
    output cpu_pkg::word_t result,
    output cpu_pkg::word_t alu_flags
);

    logic [16:0] sum;
    logic [16:0] diff;
    cpu_pkg::word_t alu_out;
    logic carry_next;
    logic overflow_next;
    logic carry_q;
    logic overflow_q;

    assign sum = {1'b0, dst_val} + {1'b0, src_val};
    assign diff = {1'b0, dst_val} - {1'b0, src_val};

    always_comb begin
        alu_out = src_val;
        carry_next = 1'b0;
        overflow_next = 1'b0;
        case (op)
            cpu_pkg::op_add: begin
                alu_out = sum[15:0];
                carry_next = sum[16];
                overflow_next = (dst_val[15] == src_val[15]) && (sum[15] != dst_val[15]);
            end
            cpu_pkg::op_sub: begin
                alu_out = diff[15:0];
                // borrow
                carry_next = diff[16];
                overflow_next = (dst_val[15] != src_val[15]) && (diff[15] != dst_val[15]);
            end
            cpu_pkg::op_and: alu_out = dst_val & src_val;
            cpu_pkg::op_or: alu_out = dst_val | src_val;
            cpu_pkg::op_xor: alu_out = dst_val ^ src_val;
            cpu_pkg::op_shl: alu_out = dst_val << src_val[3:0];
            cpu_pkg::op_shr: alu_out = dst_val >> src_val[3:0];
            default: alu_out = src_val;
        endcase
    end

    // copies latch the source one step early
    always_ff @(posedge cpu_clock) begin
        if (step == cpu_pkg::step_execute) begin
            result <= alu_out;
        end else if (step == cpu_pkg::step_source && copy_op) begin
            result <= src_val;
        end
    end

    always_ff @(posedge cpu_clock) begin
        if (reset) begin
            carry_q <= 1'b0;
            overflow_q <= 1'b0;
        end else if (step == cpu_pkg::step_execute) begin
            carry_q <= carry_next;
            overflow_q <= overflow_next;
        end
    end

    always_comb begin
        alu_flags = flags;
        alu_flags[cpu_pkg::flag_zero] = (result == '0);
        alu_flags[cpu_pkg::flag_negative] = result[15];
        alu_flags[cpu_pkg::flag_carry] = carry_q;
        alu_flags[cpu_pkg::flag_overflow] = overflow_q;
    end

endmodule

`default_nettype wire

//--- source/bus_interface.sv
`timescale 1ns/1ns
`default_nettype none

module bus_interface (
    input wire cpu_clock,
    input wire reset,
    input wire cpu_pkg::step_t step,
    input wire cpu_pkg::word_t pc,
    input wire cpu_pkg::word_t src_base,
    input wire cpu_pkg::word_t dst_base,
    input wire src_mem,
    input wire dst_mem,
    input wire copy_op,
    input wire store_en,
    input wire cpu_pkg::word_t result,
    input wire cpu_pkg::word_t mem_read_data,
    output cpu_pkg::word_t mem_address,
    output logic mem_read,
    output logic mem_write,
    output cpu_pkg::word_t mem_write_data,
    output cpu_pkg::word_t src_val,
    output cpu_pkg::word_t dst_val
);

    cpu_pkg::word_t src_in;
    cpu_pkg::word_t dst_in;
    cpu_pkg::word_t src_q;
    cpu_pkg::word_t dst_q;

    // ==============================
    // bus requests
    // ==============================

    always_comb begin
        case (step)
            cpu_pkg::step_operand: mem_address = src_base;
            cpu_pkg::step_source: mem_address = dst_base;
            cpu_pkg::step_writeback: mem_address = dst_base;
            default: mem_address = pc;
        endcase
    end

    // a copy never needs the old destination
    assign mem_read = (step == cpu_pkg::step_fetch_low)
                    | (step == cpu_pkg::step_fetch_high)
                    | ((step == cpu_pkg::step_operand) & src_mem)
                    | ((step == cpu_pkg::step_source) & dst_mem & ~copy_op);

    assign mem_write = (step == cpu_pkg::step_writeback) & store_en & dst_mem;
    assign mem_write_data = result;

    // ==============================
    // operand capture
    // ==============================

    // data shows up one step after its read
    assign src_in = src_mem ? mem_read_data : src_base;
    assign dst_in = dst_mem ? mem_read_data : dst_base;

    always_ff @(posedge cpu_clock) begin
        if (reset) begin
            src_q <= '0;
            dst_q <= '0;
        end else begin
            if (step == cpu_pkg::step_source) begin
                src_q <= src_in;
            end
            if (step == cpu_pkg::step_execute) begin
                dst_q <= dst_in;
            end
        end
    end

    // pass through while capturing so the alu sees it right away
    assign src_val = (step == cpu_pkg::step_source) ? src_in : src_q;
    assign dst_val = (step == cpu_pkg::step_execute) ? dst_in : dst_q;

endmodule

`default_nettype wire

//--- source/cpu.sv
`timescale 1ns/1ns
`default_nettype none

module cpu (
    input wire cpu_clock,
    input wire reset,
    output cpu_pkg::word_t mem_address,
    output logic mem_read,
    output logic mem_write,
    output cpu_pkg::word_t mem_write_data,
    input wire cpu_pkg::word_t mem_read_data
);

    cpu_pkg::step_t step;
    cpu_pkg::operand_t src;
    cpu_pkg::operand_t dst;
    cpu_pkg::alu_op_t op;
    cpu_pkg::word_t imm;
    logic src_mem;
    logic dst_mem;
    logic copy_op;
    logic store_en;
    cpu_pkg::word_t pc;
    cpu_pkg::word_t flags;
    cpu_pkg::word_t src_base;
    cpu_pkg::word_t dst_base;
    cpu_pkg::word_t src_val;
    cpu_pkg::word_t dst_val;
    cpu_pkg::word_t result;
    cpu_pkg::word_t alu_flags;

    step_sequencer i_step_sequencer (
        .cpu_clock(cpu_clock), .reset(reset), .copy_op(copy_op), .step(step)
    );

    instruction_decoder i_instruction_decoder (
        .cpu_clock(cpu_clock), .reset(reset), .step(step),
        .mem_read_data(mem_read_data), .flags(flags),
        .src(src), .dst(dst), .op(op), .imm(imm),
        .src_mem(src_mem), .dst_mem(dst_mem), .copy_op(copy_op), .store_en(store_en)
    );

    register_file i_register_file (
        .cpu_clock(cpu_clock), .reset(reset), .step(step),
        .src(src), .dst(dst), .imm(imm), .store_en(store_en),
        .result(result), .alu_flags(alu_flags), .copy_op(copy_op),
        .pc(pc), .flags(flags), .src_base(src_base), .dst_base(dst_base)
    );

    execute_unit i_execute_unit (
        .cpu_clock(cpu_clock), .reset(reset), .step(step),
        .op(op), .copy_op(copy_op), .src_val(src_val), .dst_val(dst_val),
        .flags(flags), .result(result), .alu_flags(alu_flags)
    );

    bus_interface i_bus_interface (
        .cpu_clock(cpu_clock), .reset(reset), .step(step),
        .pc(pc), .src_base(src_base), .dst_base(dst_base),
        .src_mem(src_mem), .dst_mem(dst_mem), .copy_op(copy_op), .store_en(store_en),
        .result(result), .mem_read_data(mem_read_data),
        .mem_address(mem_address), .mem_read(mem_read), .mem_write(mem_write),
        .mem_write_data(mem_write_data), .src_val(src_val), .dst_val(dst_val)
    );

endmodule

`default_nettype wire

//--- verif/cpu_properties.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_properties (
    input wire cpu_clock,
    input wire reset,
    input wire cpu_pkg::step_t step,
    input wire mem_read,
    input wire mem_write
);

    // one direction at a time on the bus
    read_write_exclusive: assert property (
        @(posedge cpu_clock) disable iff (reset) !(mem_read && mem_write)
    ) else $error("mem_read and mem_write are high together");

    write_in_writeback: assert property (
        @(posedge cpu_clock) disable iff (reset)
            mem_write |-> (step == cpu_pkg::step_writeback)
    ) else $error("mem_write is high outside the writeback step");

    no_write_after_reset: assert property (
        @(posedge cpu_clock) reset |=> !mem_write
    ) else $error("mem_write is high in the cycle after reset");

endmodule

bind bus_interface cpu_properties i_cpu_properties (
    .cpu_clock(cpu_clock),
    .reset(reset),
    .step(step),
    .mem_read(mem_read),
    .mem_write(mem_write)
);

`default_nettype wire

//--- verif/cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;

    localparam int num_instructions = 400;
    localparam int timeout_cycles = num_instructions * 6 + 100;
    localparam logic [15:0] lfsr_seed = 16'd43801;

    logic cpu_clock = 1'b0;
    logic reset;
    cpu_pkg::word_t mem_address;
    logic mem_read;
    logic mem_write;
    cpu_pkg::word_t mem_write_data;
    cpu_pkg::word_t mem_read_data;

    // memory behind the dut bus and the model's own copy
    cpu_pkg::word_t bus_mem [0:255];
    cpu_pkg::word_t model_mem [0:255];

    cpu_pkg::word_t m_pc;
    cpu_pkg::word_t m_flags;
    cpu_pkg::word_t m_gpr [0:7];

    // expected bus activity of the current instruction
    cpu_pkg::word_t exp_fetch;
    logic exp_copy;
    logic exp_src_read;
    cpu_pkg::word_t exp_src_addr;
    logic exp_dst_read;
    cpu_pkg::word_t exp_dst_addr;
    logic exp_store;
    cpu_pkg::word_t exp_store_data;

    logic [15:0] lfsr_state;
    int cycle_count = 0;
    int check_failures;
    int store_count;
    int instr_index;

    cpu i_dut (
        .cpu_clock(cpu_clock),
        .reset(reset),
        .mem_address(mem_address),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .mem_write_data(mem_write_data),
        .mem_read_data(mem_read_data)
    );

    always #10 cpu_clock = ~cpu_clock;

    always @(posedge cpu_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: run did not end within %0d cycles", timeout_cycles);
            $display("FAIL: see errors above");
            $fatal(1, "simulation timed out");
        end
    end

    // ==============================
    // bus memory with one cycle latency
    // ==============================

    initial begin : memory_model
        logic req_read;
        logic req_write;
        cpu_pkg::word_t req_address;
        cpu_pkg::word_t req_data;
        mem_read_data = 16'h0000;
        forever begin
            @(negedge cpu_clock);
            req_read = mem_read;
            req_write = mem_write;
            req_address = mem_address;
            req_data = mem_write_data;
            @(posedge cpu_clock);
            #1;
            if (req_read === 1'b1) begin
                mem_read_data = bus_mem[req_address[8:1]];
            end
            if (req_write === 1'b1) begin
                bus_mem[req_address[8:1]] = req_data;
            end
        end
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    function automatic logic [15:0] take_bits(input int count);
        logic [15:0] value;
        value = 16'h0000;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[14:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic fill_memories;
        logic [15:0] upper;
        logic [15:0] lower;
        logic [7:0] index;
        for (int a = 0; a < 256; a++) begin
            index = a[7:0];
            upper = take_bits(12);
            // op bit 3 held low for ops 0 to 7 only
            lower = take_bits(3);
            bus_mem[index] = {upper[11:0], 1'b0, lower[2:0]};
            model_mem[index] = {upper[11:0], 1'b0, lower[2:0]};
        end
    endtask

    // ==============================
    // ISA model
    // ==============================

    function automatic cpu_pkg::word_t operand_value(
        input cpu_pkg::operand_t code,
        input cpu_pkg::word_t imm
    );
        cpu_pkg::word_t value;
        case (code)
            4'd0: value = m_pc;
            4'd7: value = imm;
            4'd8: value = m_flags;
            default: value = m_gpr[code[2:0]];
        endcase
        return value;
    endfunction

    function automatic cpu_pkg::word_t memory_address(
        input cpu_pkg::operand_t code,
        input cpu_pkg::word_t imm,
        input logic indexed
    );
        cpu_pkg::operand_t base;
        cpu_pkg::word_t address;
        base = code - 4'd8;
        if (code == 4'd15) begin
            address = imm;
        end else if (indexed) begin
            address = m_gpr[base[2:0]] + imm;
        end else begin
            address = m_gpr[base[2:0]];
        end
        return address;
    endfunction

    function automatic logic effect_holds(input logic [2:0] effect, input cpu_pkg::word_t f);
        logic holds;
        case (effect)
            3'd0: holds = 1'b1;
            3'd1: holds = f[cpu_pkg::flag_zero];
            3'd2: holds = !f[cpu_pkg::flag_zero];
            3'd3: holds = f[cpu_pkg::flag_carry];
            3'd4: holds = !f[cpu_pkg::flag_carry];
            3'd5: holds = f[cpu_pkg::flag_negative];
            3'd6: holds = f[cpu_pkg::flag_overflow];
            default: holds = 1'b0;
        endcase
        return holds;
    endfunction

    task automatic model_instruction;
        cpu_pkg::word_t word0;
        cpu_pkg::word_t imm;
        cpu_pkg::word_t next_addr;
        cpu_pkg::word_t src_v;
        cpu_pkg::word_t dst_v;
        cpu_pkg::word_t res;
        cpu_pkg::word_t old_flags;
        cpu_pkg::operand_t src;
        cpu_pkg::operand_t dst;
        logic [3:0] op;
        int total;
        logic taken;
        logic carry;
        logic overflow;
        exp_fetch = m_pc;
        next_addr = m_pc + 16'd2;
        word0 = model_mem[m_pc[8:1]];
        imm = model_mem[next_addr[8:1]];
        m_pc = m_pc + 16'd4;
        old_flags = m_flags;
        src = word0[15:12];
        dst = word0[11:8];
        op = word0[3:0];
        taken = effect_holds(word0[6:4], m_flags);
        exp_copy = (op == 4'd0) || op[3];
        exp_src_read = (src > 4'd8);
        exp_src_addr = memory_address(src, imm, 1'b1);
        src_v = exp_src_read ? model_mem[exp_src_addr[8:1]] : operand_value(src, imm);
        // copies skip the destination read
        exp_dst_read = (dst > 4'd8) && !exp_copy;
        exp_dst_addr = memory_address(dst, imm, 1'b0);
        dst_v = (dst > 4'd8) ? model_mem[exp_dst_addr[8:1]] : operand_value(dst, imm);
        carry = 1'b0;
        overflow = 1'b0;
        case (op)
            4'd1: begin
                res = dst_v + src_v;
                total = int'(dst_v) + int'(src_v);
                carry = (total > 65535);
                // signed result outside the 16-bit range
                total = int'($signed(dst_v)) + int'($signed(src_v));
                overflow = (total > 32767) || (total < -32768);
            end
            4'd2: begin
                res = dst_v - src_v;
                carry = (dst_v < src_v);
                total = int'($signed(dst_v)) - int'($signed(src_v));
                overflow = (total > 32767) || (total < -32768);
            end
            4'd3: res = dst_v & src_v;
            4'd4: res = dst_v | src_v;
            4'd5: res = dst_v ^ src_v;
            4'd6: res = dst_v << src_v[3:0];
            4'd7: res = dst_v >> src_v[3:0];
            default: res = src_v;
        endcase
        exp_store = taken && (dst > 4'd8);
        exp_store_data = res;
        if (taken) begin
            case (dst)
                4'd0: m_pc = res;
                4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6: m_gpr[dst[2:0]] = res;
                // code 7 discards the result
                4'd7: ;
                4'd8: m_flags = res;
                default: model_mem[exp_dst_addr[8:1]] = res;
            endcase
        end
        // alu flags win over a flags destination
        // upper flag bits stay as they were
        if (!exp_copy) begin
            m_flags = old_flags;
            m_flags[cpu_pkg::flag_zero] = (res == 16'h0000);
            m_flags[cpu_pkg::flag_negative] = res[15];
            m_flags[cpu_pkg::flag_carry] = carry;
            m_flags[cpu_pkg::flag_overflow] = overflow;
        end
    endtask

    // ==============================
    // compare tasks
    // ==============================

    task automatic check_word(input string name, input cpu_pkg::word_t got,
                              input cpu_pkg::word_t expected);
        if (got !== expected) begin
            check_failures++;
            $display("CHECK FAILED at %0t ns: %s expected %h got %h (instruction %0d)",
                     $time, name, expected, got, instr_index);
            $display("FAIL: see errors above");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic check_strobe(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            check_failures++;
            $display("CHECK FAILED at %0t ns: %s expected %b got %b (instruction %0d)",
                     $time, name, expected, got, instr_index);
            $display("FAIL: see errors above");
            $fatal(1, "stopping at first error");
        end
    endtask

    // one bus sample per cycle at the falling edge
    task automatic check_instruction;
        int cycles;
        logic exp_read;
        logic exp_write;
        cpu_pkg::word_t exp_address;
        cycles = exp_copy ? 5 : 6;
        for (int c = 0; c < cycles; c++) begin
            @(negedge cpu_clock);
            exp_read = 1'b0;
            exp_address = 16'h0000;
            case (c)
                0: begin
                    exp_read = 1'b1;
                    exp_address = exp_fetch;
                end
                1: begin
                    exp_read = 1'b1;
                    exp_address = exp_fetch + 16'd2;
                end
                2: begin
                    exp_read = exp_src_read;
                    exp_address = exp_src_addr;
                end
                3: begin
                    exp_read = exp_dst_read;
                    exp_address = exp_dst_addr;
                end
                default: exp_read = 1'b0;
            endcase
            exp_write = (c == cycles - 1) && exp_store;
            check_strobe("mem_read", mem_read, exp_read);
            if (exp_read) begin
                check_word("mem_address", mem_address, exp_address);
            end
            check_strobe("mem_write", mem_write, exp_write);
            if (exp_write) begin
                check_word("mem_address", mem_address, exp_dst_addr);
                check_word("mem_write_data", mem_write_data, exp_store_data);
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        check_failures = 0;
        store_count = 0;
        instr_index = 0;
        lfsr_state = lfsr_seed;
        fill_memories();
        m_pc = cpu_pkg::reset_pc;
        m_flags = cpu_pkg::reset_flags;
        m_gpr = '{default: 16'h0000};
        @(posedge cpu_clock);
        @(negedge cpu_clock);
        check_strobe("mem_write", mem_write, 1'b0);
        @(posedge cpu_clock);
        #1;
        reset = 1'b0;
        for (instr_index = 0; instr_index < num_instructions; instr_index++) begin
            model_instruction();
            if (exp_store) begin
                store_count++;
            end
            check_instruction();
        end
        $display("%0d instructions run, %0d stores seen", num_instructions, store_count);
        if (check_failures == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
source/cpu_pkg.sv
source/step_sequencer.sv
source/instruction_decoder.sv
source/register_file.sv
source/execute_unit.sv
source/bus_interface.sv
source/cpu.sv
verif/cpu_properties.sv
verif/cpu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the cpu testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module cpu_tb -f list.f -o cpu_tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/cpu_tb_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi
if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

echo "simulation passed"
exit 0
